// ==== hdl/cam_pkg.sv ====
//==========================================================================
// Camera front end constants, bar colours and pixel types
//==========================================================================
`default_nettype none

package cam_pkg;

	localparam int CAM_BYTE_W = 8;	// Camera bus width
	localparam int PIX_W      = 16;
	localparam int H_NUM      = 1280;	// Columns per line
	localparam int BAR_W      = 160;	// Columns per bar
	localparam int COL_W      = 12;

	// Bar colours in BGR565 codes
	localparam logic [PIX_W-1:0] BAR_RED     = 16'h001F;
	localparam logic [PIX_W-1:0] BAR_GREEN   = 16'h07E0;
	localparam logic [PIX_W-1:0] BAR_BLUE    = 16'hF800;
	localparam logic [PIX_W-1:0] BAR_YELLOW  = 16'h07FF;
	localparam logic [PIX_W-1:0] BAR_CYAN    = 16'hFFE0;
	localparam logic [PIX_W-1:0] BAR_MAGENTA = 16'hF81F;
	localparam logic [PIX_W-1:0] BAR_WHITE   = 16'hFFFF;
	localparam logic [PIX_W-1:0] BAR_BLACK   = 16'h0000;

	typedef logic [CAM_BYTE_W-1:0] cam_byte_t;
	typedef logic [COL_W-1:0]      col_t;

	typedef struct packed {
		logic [4:0] r;	// Top bits
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		cam_byte_t hi;
		cam_byte_t lo;
	} byte_pair_t;

	// Written as bytes by the packer, read as fields by the formatter
	typedef union packed {
		rgb565_t    rgb;
		byte_pair_t bytes;
	} pix_word_u;

	typedef struct packed {
		logic      vsync;
		logic      href;
		cam_byte_t data;
	} cam_in_t;

	typedef struct packed {
		logic href_d;
		col_t col;
		logic sof_pend;
		logic sol_pend;
	} line_ctl_t;

	typedef struct packed {
		logic      valid;
		pix_word_u word;
	} packed_pix_t;

	typedef struct packed {
		logic      valid;
		logic      sof;
		logic      sol;
		pix_word_u data;
	} pixel_out_t;

endpackage

`default_nettype wire

// ==== hdl/cam_capture_ctrl.sv ====
//==========================================================================
// Sync sampling, edge detection, column counter and start-of flags
//==========================================================================
`default_nettype none

module cam_capture_ctrl import cam_pkg::*; (
	input  wire         i_clk,
	input  wire         i_rst_n,
	input  wire cam_in_t     i_cam,
	input  wire packed_pix_t i_pix,
	output line_ctl_t   o_line
);

	logic href_d;	// Aligned with the registered data byte
	logic href_q;
	logic vsync_d;
	logic vsync_q;
	logic href_rise;
	logic vsync_rise;
	col_t col;
	logic sof_pend;
	logic sol_pend;

	assign href_rise  = href_d & ~href_q;
	assign vsync_rise = vsync_d & ~vsync_q;

	// Sync sampling
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			href_d  <= 1'b0;
			href_q  <= 1'b0;
			vsync_d <= 1'b0;
			vsync_q <= 1'b0;
		end else begin
			href_d  <= i_cam.href;
			href_q  <= href_d;
			vsync_d <= i_cam.vsync;
			vsync_q <= vsync_d;
		end
	end

	//==========================================================================
	// Column counter, restarts on either sync edge
	//==========================================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col <= '0;
		end else if (vsync_rise || href_rise) begin
			col <= '0;
		end else if (i_pix.valid) begin
			if (col == col_t'(H_NUM - 1))
				col <= '0;	// Wrap at end of line
			else
				col <= col + col_t'(1);
		end
	end

	// Pending flags wait for the first pixel, a new edge wins over the clear
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sof_pend <= 1'b0;
			sol_pend <= 1'b0;
		end else begin
			if (vsync_rise)
				sof_pend <= 1'b1;
			else if (i_pix.valid)
				sof_pend <= 1'b0;

			if (href_rise)
				sol_pend <= 1'b1;
			else if (i_pix.valid)
				sol_pend <= 1'b0;
		end
	end

	assign o_line.href_d   = href_d;
	assign o_line.col      = col;
	assign o_line.sof_pend = sof_pend;
	assign o_line.sol_pend = sol_pend;

endmodule

`default_nettype wire

// ==== hdl/cam_byte_packer.sv ====
//==========================================================================
// Camera byte register and high/low byte pairing into 16-bit words
//==========================================================================
`default_nettype none

module cam_byte_packer import cam_pkg::*; (
	input  wire         i_clk,
	input  wire         i_rst_n,
	input  wire cam_in_t     i_cam,
	input  wire line_ctl_t   i_line,
	output packed_pix_t o_pix
);

	cam_byte_t data_d;	// Same cycle as i_line.href_d
	cam_byte_t hi_byte;
	logic      phase;	// 0 on high byte, 1 on low byte
	logic      valid_q;
	pix_word_u word_q;

	always_ff @(posedge i_clk) begin
		data_d <= i_cam.data;
	end

	// Pairing phase and output strobe
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_line.href_d & phase;
			if (i_line.href_d)
				phase <= ~phase;
			else
				phase <= 1'b0;	// Drops an odd trailing byte
		end
	end

	// Byte storage
	always_ff @(posedge i_clk) begin
		if (i_line.href_d && !phase)
			hi_byte <= data_d;

		if (i_line.href_d && phase) begin
			word_q.bytes.hi <= hi_byte;
			word_q.bytes.lo <= data_d;
		end
	end

	assign o_pix.valid = valid_q;
	assign o_pix.word  = word_q;

endmodule

`default_nettype wire

// ==== hdl/color_bar_gen.sv ====
//==========================================================================
// Eight-bar colour pattern lookup, registered per column
//==========================================================================
`default_nettype none

module color_bar_gen import cam_pkg::*; (
	input  wire     i_clk,
	input  wire     i_rst_n,
	input  wire col_t    i_col,
	output rgb565_t o_bar
);

	logic [2:0] bar_idx;
	rgb565_t    bar_q;

	// Column never passes H_NUM-1 so the index fits in 3 bits
	assign bar_idx = 3'(i_col / col_t'(BAR_W));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bar_q <= BAR_BLACK;
		end else begin
			case (bar_idx)
				3'd0:    bar_q <= BAR_RED;
				3'd1:    bar_q <= BAR_GREEN;
				3'd2:    bar_q <= BAR_BLUE;
				3'd3:    bar_q <= BAR_YELLOW;
				3'd4:    bar_q <= BAR_CYAN;
				3'd5:    bar_q <= BAR_MAGENTA;
				3'd6:    bar_q <= BAR_WHITE;
				default: bar_q <= BAR_BLACK;
			endcase
		end
	end

	assign o_bar = bar_q;

endmodule

`default_nettype wire

// ==== hdl/pixel_formatter.sv ====
//==========================================================================
// Red/blue swap, test bar select and output pixel register
//==========================================================================
`default_nettype none

module pixel_formatter import cam_pkg::*; (
	input  wire         i_clk,
	input  wire         i_rst_n,
	input  wire packed_pix_t i_pix,
	input  wire line_ctl_t   i_line,
	input  wire rgb565_t     i_bar,
	input  wire         i_swap_rb,
	input  wire         i_test_bar,
	output pixel_out_t  o_pix
);

	rgb565_t   cam_rgb;
	rgb565_t   fmt_rgb;
	logic      valid_q;
	logic      sof_q;
	logic      sol_q;
	pix_word_u data_q;

	assign cam_rgb = i_pix.word.rgb;

	// Source select, bar pattern bypasses the swap
	always_comb begin
		fmt_rgb = cam_rgb;
		if (i_test_bar) begin
			fmt_rgb = i_bar;
		end else if (i_swap_rb) begin
			fmt_rgb.r = cam_rgb.b;
			fmt_rgb.b = cam_rgb.r;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			sof_q   <= 1'b0;
			sol_q   <= 1'b0;
		end else begin
			valid_q <= i_pix.valid;
			sof_q   <= i_pix.valid & i_line.sof_pend;	// First pixel of frame
			sol_q   <= i_pix.valid & i_line.sol_pend;	// First pixel of line
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_pix.valid)
			data_q.rgb <= fmt_rgb;
	end

	assign o_pix.valid = valid_q;
	assign o_pix.sof   = sof_q;
	assign o_pix.sol   = sol_q;
	assign o_pix.data  = data_q;

endmodule

`default_nettype wire

// ==== hdl/cam_front_top.sv ====
//==========================================================================
// Camera pixel front end top, control plus datapath instances
//==========================================================================
`default_nettype none

module cam_front_top import cam_pkg::*; (
	input  wire        cmos1_pclk,
	input  wire        core_rst_n,
	input  wire cam_in_t    i_cam,
	input  wire        i_swap_rb,
	input  wire        i_test_bar,
	output pixel_out_t o_pix
);

	line_ctl_t   line_ctl;	// Control to datapath
	packed_pix_t packed_pix;
	rgb565_t     bar_rgb;

	cam_capture_ctrl u_cam_capture_ctrl (
		.i_clk   (cmos1_pclk),
		.i_rst_n (core_rst_n),
		.i_cam   (i_cam),
		.i_pix   (packed_pix),	// Advances the column
		.o_line  (line_ctl)
	);

	cam_byte_packer u_cam_byte_packer (
		.i_clk   (cmos1_pclk),
		.i_rst_n (core_rst_n),
		.i_cam   (i_cam),
		.i_line  (line_ctl),
		.o_pix   (packed_pix)
	);

	color_bar_gen u_color_bar_gen (
		.i_clk   (cmos1_pclk),
		.i_rst_n (core_rst_n),
		.i_col   (line_ctl.col),
		.o_bar   (bar_rgb)
	);

	// Output stage
	pixel_formatter u_pixel_formatter (
		.i_clk      (cmos1_pclk),
		.i_rst_n    (core_rst_n),
		.i_pix      (packed_pix),
		.i_line     (line_ctl),
		.i_bar      (bar_rgb),
		.i_swap_rb  (i_swap_rb),
		.i_test_bar (i_test_bar),
		.o_pix      (o_pix)
	);

endmodule

`default_nettype wire

// ==== test/cam_front_assert.sv ====
//==========================================================================
// Concurrent checks on the output pixel flags, bound into the formatter
//==========================================================================
`default_nettype none

module cam_front_assert import cam_pkg::*; (
	input wire             i_clk,
	input wire             i_rst_n,
	input wire pixel_out_t i_pix
);

	// Start flags only ride on a valid pixel
	a_flags_need_valid: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_pix.sof || i_pix.sol) |-> i_pix.valid
	) else $error("sof or sol high without a valid pixel");

	a_valid_single: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		i_pix.valid |=> !i_pix.valid
	) else $error("o_pix.valid held high for two cycles");

	// Output flops cleared by the edge taken under reset
	a_idle_in_reset: assert property (
		@(posedge i_clk)
		!i_rst_n |=> (!i_pix.valid && !i_pix.sof && !i_pix.sol)
	) else $error("o_pix not idle during reset");

endmodule

bind pixel_formatter cam_front_assert u_cam_front_assert (
	.i_clk   (i_clk),
	.i_rst_n (i_rst_n),
	.i_pix   (o_pix)
);

`default_nettype wire

// ==== test/tb_cam_front.sv ====
//==========================================================================
// Testbench for the camera front end, golden file stimulus and checks
//==========================================================================
`default_nettype none

module tb_cam_front import cam_pkg::*; ();

	typedef struct packed {
		logic      chk;	// Data compared only where a value is known
		logic      sof;
		logic      sol;
		pix_word_u data;
	} exp_pix_t;

	typedef struct packed {
		logic [8*16-1:0] name;
		logic            swap;
		logic            bar;
		int              lines;
		int              bytes;	// Bytes per line
	} test_rec_t;

	logic       cmos1_pclk;
	logic       core_rst_n;
	cam_in_t    i_cam;
	logic       i_swap_rb;
	logic       i_test_bar;
	pixel_out_t o_pix;

	exp_pix_t  exp_q[$];
	test_rec_t tests[$];
	int        cp_col[$];	// Bar checkpoints, pixel index within the line
	pix_word_u cp_rgb[$];
	string     cur_test;
	int        exp_total;
	int        rx_total;

	cam_front_top u_cam_front_top (
		.cmos1_pclk (cmos1_pclk),
		.core_rst_n (core_rst_n),
		.i_cam      (i_cam),
		.i_swap_rb  (i_swap_rb),
		.i_test_bar (i_test_bar),
		.o_pix      (o_pix)
	);

	always #50 cmos1_pclk = ~cmos1_pclk;

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string test, input pix_word_u exp, input pix_word_u act);
		if (act !== exp) begin
			$display("** Error %s pixel data: expected %h, actual %h", test, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_start_flags(input string test, input logic exp_sof,
			input logic exp_sol, input pixel_out_t act);
		if ({act.sof, act.sol} !== {exp_sof, exp_sol}) begin
			$display("** Error %s sof/sol: expected %b%b, actual %b%b",
				test, exp_sof, exp_sol, act.sof, act.sol);
			stop_with_failure();
		end
	endtask

	function automatic logic find_checkpoint(input int col, output pix_word_u rgb);
		rgb = '0;
		foreach (cp_col[i]) begin
			if (cp_col[i] == col) begin
				rgb = cp_rgb[i];
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	//==========================================================================
	// Golden file, test records and bar checkpoints
	//==========================================================================
	task automatic load_golden();
		int              fd;
		string           line;
		logic [7:0]      tag;
		logic [8*16-1:0] name_v;
		int              swap;
		int              bar;
		int              lines;
		int              bytes;
		int              col;
		logic [15:0]     rgb;
		test_rec_t       rec;
		fd = $fopen("test/cam_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file test/cam_golden.txt");
			stop_with_failure();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					void'($sscanf(line, "%s", tag));
					if (tag == "T") begin
						void'($sscanf(line, "%s %s %d %d %d %d",
							tag, name_v, swap, bar, lines, bytes));
						rec.name  = name_v;
						rec.swap  = (swap != 0);
						rec.bar   = (bar != 0);
						rec.lines = lines;
						rec.bytes = bytes;
						tests.push_back(rec);
					end else if (tag == "C") begin
						void'($sscanf(line, "%s %d %h", tag, col, rgb));
						cp_col.push_back(col);
						cp_rgb.push_back(rgb);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_cam(input logic vs, input logic hr, input cam_byte_t d);
		@(posedge cmos1_pclk);
		i_cam <= '{vsync: vs, href: hr, data: d};
	endtask

	// Expected pixel from a byte pair, high byte first, r in the top five bits
	task automatic push_expected(input test_rec_t rec, input int pix_idx,
			input logic sof, input cam_byte_t hi, input cam_byte_t lo);
		exp_pix_t    e;
		logic [15:0] w;
		w      = {hi, lo};
		e.chk  = 1'b1;
		e.sof  = sof;
		e.sol  = (pix_idx == 0);
		e.data = w;
		if (rec.bar) begin
			e.chk = find_checkpoint(pix_idx, e.data);	// Bar bypasses the swap
		end else if (rec.swap) begin
			e.data = {w[4:0], w[10:5], w[15:11]};	// Red and blue exchanged
		end
		exp_q.push_back(e);
		exp_total++;
	endtask

	task automatic run_test(input test_rec_t rec);
		cam_byte_t hi;
		cam_byte_t cur;
		logic      first;
		int        l;
		int        j;
		int        n;
		cur_test = string'(rec.name);
		hi       = '0;
		first    = 1'b1;
		@(posedge cmos1_pclk);
		i_swap_rb  <= rec.swap;
		i_test_bar <= rec.bar;
		repeat (2) drive_cam(1'b1, 1'b0, '0);	// New frame
		repeat (4) drive_cam(1'b0, 1'b0, '0);
		for (l = 0; l < rec.lines; l++) begin
			for (j = 0; j < rec.bytes; j++) begin
				cur = cam_byte_t'($urandom());
				drive_cam(1'b0, 1'b1, cur);
				if (j % 2 == 0) begin
					hi = cur;
				end else begin
					push_expected(rec, j / 2, first, hi, cur);
					first = 1'b0;
				end
			end
			repeat (6) drive_cam(1'b0, 1'b0, '0);	// Line gap
		end
		n = 0;
		while (exp_q.size() != 0 && n < 100) begin
			@(posedge cmos1_pclk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout in test %s, %0d pixels never reached the output",
				cur_test, exp_q.size());
			stop_with_failure();
		end
		repeat (8) @(posedge cmos1_pclk);	// Idle, no stray pixels allowed
	endtask

	// Sampled mid-cycle where o_pix is stable
	always @(negedge cmos1_pclk) begin : pixel_monitor
		exp_pix_t e;
		if (o_pix.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected output pixel in test %s, no pixel was pending", cur_test);
				stop_with_failure();
			end else begin
				e = exp_q.pop_front();
				if (e.chk)
					check_word(cur_test, e.data, o_pix.data);
				check_start_flags(cur_test, e.sof, e.sol, o_pix);
				rx_total++;
			end
		end
	end

	initial begin
		void'($urandom(46));
		cmos1_pclk = 1'b0;
		core_rst_n = 1'b0;
		i_cam      = '0;
		i_swap_rb  = 1'b0;
		i_test_bar = 1'b0;
		cur_test   = "reset";
		exp_total  = 0;
		rx_total   = 0;
		load_golden();
		repeat (3) @(posedge cmos1_pclk);
		core_rst_n <= 1'b1;
		foreach (tests[i])
			run_test(tests[i]);
		if (tests.size() > 0 && rx_total == exp_total && exp_q.size() == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Run incomplete, %0d tests, %0d pixels expected, %0d received",
				tests.size(), exp_total, rx_total);
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== test/cam_golden.txt ====
# T name swap bar lines bytes_per_line    test record, one frame each
# C pixel_column expected_bar_colour       bar checkpoint, BGR565 hex
T single    0 0 1 1
T plain     0 0 3 64
T swap      1 0 2 40
T odd       0 0 2 11
T bar_long  0 1 1 2600
T bar_short 0 1 2 400
T swap_bar  1 1 1 340
C 0    001F
C 159  001F
C 160  07E0
C 199  07E0
C 319  07E0
C 320  F800
C 479  F800
C 480  07FF
C 640  FFE0
C 800  F81F
C 960  FFFF
C 1119 FFFF
C 1120 0000
C 1279 0000
C 1280 001F
C 1299 001F

// ==== filelist.f ====
hdl/cam_pkg.sv
hdl/cam_capture_ctrl.sv
hdl/cam_byte_packer.sv
hdl/color_bar_gen.sv
hdl/pixel_formatter.sv
hdl/cam_front_top.sv
test/cam_front_assert.sv
test/tb_cam_front.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the camera front end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_cam_front \
	-f filelist.f \
	-o sim_tb_cam_front
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb_cam_front
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run failed with status $status"
	exit $status
fi

exit 0
